// ==== hw/burst_gearbox_macros.svh ====
`ifndef BURST_GEARBOX_MACROS_SVH
`define BURST_GEARBOX_MACROS_SVH

// Word address width on both the master and the slave side
`define GBX_ADDR_WIDTH 16

// Master burst count width, wide enough to hold a count of 128
`define GBX_MASTER_BURST_WIDTH 8

// Slave burst count width, wide enough to hold a count of 8
`define GBX_SLAVE_BURST_WIDTH 4

// Largest burst the slave accepts, in beats
`define GBX_SLAVE_MAX_BURST 8

// Page length in addresses
// It is a power of two and larger than the largest slave burst
`define GBX_PAGE_SIZE 64

`endif

// ==== hw/burst_gearbox_pkg.sv ====
`include "burst_gearbox_macros.svh"

package burst_gearbox_pkg;

    // One word address
    typedef logic [`GBX_ADDR_WIDTH-1:0] addr_t;

    // Master burst count, counted from one, legal range 1 to 128
    typedef logic [`GBX_MASTER_BURST_WIDTH-1:0] master_count_t;

    // Slave burst count, counted from one, legal range 1 to 8
    typedef logic [`GBX_SLAVE_BURST_WIDTH-1:0] slave_count_t;

    // Command as it arrives from the master
    typedef struct packed {
        addr_t         addr;
        master_count_t count;
    } master_cmd_t;

    // One burst as it leaves for the slave
    // The last flag marks the final burst of a master command
    typedef struct packed {
        addr_t        addr;
        slave_count_t count;
        logic         last;
    } slave_burst_t;

endpackage

// ==== hw/burst_split_ctrl.sv ====
`timescale 1ns/1ps

module burst_split_ctrl
(
    input  logic clk,
    input  logic reset_n,

    // Master command handshake
    input  logic cmd_valid,
    output logic cmd_ready,

    // Slave burst handshake
    output logic burst_valid,
    input  logic burst_accept,

    // Registered flag from the remaining counter, set on the final burst
    input  logic last,

    // Datapath controls
    output logic load,
    output logic step
);

    // Two states are enough, one command is in flight at a time
    typedef enum logic
    {
        st_idle,
        st_busy
    } state_t;

    state_t state;
    state_t state_next;

    // Transfer conditions on both sides
    logic cmd_xfer;
    logic burst_xfer;
    logic final_xfer;

    // The gearbox takes a new command only while nothing is being split
    assign cmd_ready   = (state == st_idle);

    // Bursts are offered for the whole time a command is being split
    assign burst_valid = (state == st_busy);

    assign cmd_xfer    = cmd_valid & cmd_ready;
    assign burst_xfer  = burst_valid & burst_accept;

    // The transfer of the burst that carries last ends the command
    assign final_xfer  = burst_xfer & last;

    // Load captures the command in the datapath in its transfer cycle
    assign load = cmd_xfer;

    // Step moves the datapath to the next burst, except after the final one
    // There the datapath simply holds until the next load
    assign step = burst_xfer & ~last;

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (cmd_xfer)
                begin
                    state_next = st_busy;
                end
            end
            st_busy:
            begin
                // Back-pressure keeps the FSM here with the burst unchanged
                if (final_xfer)
                begin
                    state_next = st_idle;
                end
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

endmodule

// ==== hw/burst_addr_stepper.sv ====
`timescale 1ns/1ps
`include "burst_gearbox_macros.svh"

module burst_addr_stepper
(
    input  logic clk,
    input  logic reset_n,

    // Controls from the FSM
    input  logic load,
    input  logic step,

    // Start address of the incoming command
    input  burst_gearbox_pkg::addr_t cmd_addr,

    // Address of the burst on the slave side
    output burst_gearbox_pkg::addr_t cur_addr,

    // Page limit registered at cur_addr
    output burst_gearbox_pkg::slave_count_t cur_limit,

    // Page limit at the address taken on the coming edge
    output burst_gearbox_pkg::slave_count_t next_limit
);

    // Number of page offset bits
    localparam int PAGE_BITS = $clog2(`GBX_PAGE_SIZE);

    // Number of offset bits inside one full slave burst
    localparam int MAX_BITS = $clog2(`GBX_SLAVE_MAX_BURST);

    burst_gearbox_pkg::addr_t next_addr;

    // Largest burst that starts at addr and stays inside its page
    function automatic burst_gearbox_pkg::slave_count_t limit_at
    (
        burst_gearbox_pkg::addr_t addr
    );
        logic near_page_end;

        // All page offset bits above the burst offset set means the address
        // lies in the last full-burst slot of the page
        near_page_end = &addr[PAGE_BITS-1:MAX_BITS];

        if (near_page_end)
        begin
            // Only the entries up to the page end are left
            return burst_gearbox_pkg::slave_count_t'(`GBX_SLAVE_MAX_BURST) -
                   burst_gearbox_pkg::slave_count_t'(addr[MAX_BITS-1:0]);
        end
        else
        begin
            return burst_gearbox_pkg::slave_count_t'(`GBX_SLAVE_MAX_BURST);
        end
    endfunction

    // A new command starts at its own address, a step moves past the burst
    // that was just accepted, which is always cur_limit long when not last
    assign next_addr = load ? cmd_addr
                            : cur_addr + burst_gearbox_pkg::addr_t'(cur_limit);

    // The remaining counter needs this limit to decide last in the same edge
    assign next_limit = limit_at(next_addr);

    always_ff @(posedge clk)
    begin
        if (load || step)
        begin
            cur_addr  <= next_addr;
            cur_limit <= next_limit;
        end

        // Keep the limit at a legal burst size out of reset
        if (!reset_n)
        begin
            cur_limit <= burst_gearbox_pkg::slave_count_t'(`GBX_SLAVE_MAX_BURST);
        end
    end

endmodule

// ==== hw/burst_remain_counter.sv ====
`timescale 1ns/1ps

module burst_remain_counter
(
    input  logic clk,
    input  logic reset_n,

    // Controls from the FSM
    input  logic load,
    input  logic step,

    // Beat count of the incoming command
    input  burst_gearbox_pkg::master_count_t cmd_count,

    // Page limits from the address stepper
    input  burst_gearbox_pkg::slave_count_t cur_limit,
    input  burst_gearbox_pkg::slave_count_t next_limit,

    // Count of the burst on the slave side
    output burst_gearbox_pkg::slave_count_t count,

    // Set while the burst on the slave side is the final one
    output logic last
);

    // Beats still to send, including the burst now on the outputs
    burst_gearbox_pkg::master_count_t remain;
    burst_gearbox_pkg::master_count_t next_remain;
    logic next_last;

    // A step follows a burst of exactly cur_limit beats, so that is what goes
    assign next_remain = load ? cmd_count
                              : remain - burst_gearbox_pkg::master_count_t'(cur_limit);

    // The rest fits into one burst when it is no larger than the page limit
    // at the address where that burst starts
    assign next_last = (next_remain <= burst_gearbox_pkg::master_count_t'(next_limit));

    always_ff @(posedge clk)
    begin
        if (load || step)
        begin
            remain <= next_remain;
            last   <= next_last;
        end

        if (!reset_n)
        begin
            last <= 1'b1;
        end
    end

    // On the final burst the remainder is at most one full burst and fits
    // the slave count, on all others the page limit sets the size
    assign count = last ? burst_gearbox_pkg::slave_count_t'(remain) : cur_limit;

endmodule

// ==== hw/burst_gearbox_top.sv ====
`timescale 1ns/1ps

module burst_gearbox_top
(
    input  logic clk,
    input  logic reset_n,

    // Master side, one command at a time
    input  burst_gearbox_pkg::master_cmd_t cmd,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,

    // Slave side, page-limited bursts of 1 to 8 beats
    output burst_gearbox_pkg::slave_burst_t burst,
    output logic                            burst_valid,
    input  logic                            burst_accept
);

    logic load;
    logic step;
    logic last;

    burst_gearbox_pkg::addr_t        cur_addr;
    burst_gearbox_pkg::slave_count_t cur_limit;
    burst_gearbox_pkg::slave_count_t next_limit;
    burst_gearbox_pkg::slave_count_t count;

    // FSM for both handshakes
    burst_split_ctrl ctrl_i
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .burst_valid  (burst_valid),
        .burst_accept (burst_accept),
        .last         (last),
        .load         (load),
        .step         (step)
    );

    // Address and page limit of the current burst
    burst_addr_stepper stepper_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .load       (load),
        .step       (step),
        .cmd_addr   (cmd.addr),
        .cur_addr   (cur_addr),
        .cur_limit  (cur_limit),
        .next_limit (next_limit)
    );

    // Beats left, burst size and the last flag
    burst_remain_counter remain_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .load       (load),
        .step       (step),
        .cmd_count  (cmd.count),
        .cur_limit  (cur_limit),
        .next_limit (next_limit),
        .count      (count),
        .last       (last)
    );

    // All three fields come from registers, so the burst holds under back-pressure
    assign burst.addr  = cur_addr;
    assign burst.count = count;
    assign burst.last  = last;

endmodule

// ==== verification/burst_split_ref.svh ====
`ifndef BURST_SPLIT_REF_SVH
`define BURST_SPLIT_REF_SVH

`include "burst_gearbox_macros.svh"

// Room for one slave burst starting at addr
// This is a full burst, or less when the page ends sooner
function automatic int unsigned page_room(input int unsigned addr);
    int unsigned offset;
    int unsigned to_page_end;

    offset      = addr % `GBX_PAGE_SIZE;
    to_page_end = `GBX_PAGE_SIZE - offset;
    if (to_page_end < `GBX_SLAVE_MAX_BURST)
    begin
        return to_page_end;
    end
    return `GBX_SLAVE_MAX_BURST;
endfunction

// Splits one master command into the slave bursts it should produce
function automatic void build_expected
(
    input burst_gearbox_pkg::addr_t         start_addr,
    input burst_gearbox_pkg::master_count_t beats,
    ref   burst_gearbox_pkg::slave_burst_t  bursts[$]
);
    int unsigned addr;
    int unsigned left;
    int unsigned room;
    int unsigned size;
    burst_gearbox_pkg::slave_burst_t one;

    bursts.delete();
    addr = start_addr;
    left = beats;
    while (left > 0)
    begin
        room = page_room(addr);
        size = (left < room) ? left : room;
        // The address space wraps at the address width, as on the bus
        one.addr  = burst_gearbox_pkg::addr_t'(addr);
        one.count = burst_gearbox_pkg::slave_count_t'(size);
        one.last  = (left <= room);
        bursts.push_back(one);
        addr = addr + size;
        left = left - size;
    end
endfunction

`endif

// ==== verification/burst_gearbox_tb.sv ====
`timescale 1ns/1ps
`include "burst_gearbox_macros.svh"

module burst_gearbox_tb;

    `include "burst_split_ref.svh"

    // One command of the stimulus table with its expected number of bursts
    typedef struct packed {
        burst_gearbox_pkg::addr_t         addr;
        burst_gearbox_pkg::master_count_t count;
        logic                             backpressure;
        logic [7:0]                       bursts;
    } stim_t;

    localparam int NUM_CMDS = 9;

    logic clk;
    logic reset_n;
    burst_gearbox_pkg::master_cmd_t  cmd;
    logic                            cmd_valid;
    logic                            cmd_ready;
    burst_gearbox_pkg::slave_burst_t burst;
    logic                            burst_valid;
    logic                            burst_accept;

    stim_t stim_table [NUM_CMDS];
    burst_gearbox_pkg::slave_burst_t exp_q[$];
    int cycle_count;
    int timeout_limit;
    int bursts_expected;
    int unsigned seed_dummy;

    burst_gearbox_top dut_i
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .burst        (burst),
        .burst_valid  (burst_valid),
        .burst_accept (burst_accept)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Prints the reason, then the fail message, and ends the run
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_burst
    (
        input burst_gearbox_pkg::slave_burst_t got,
        input burst_gearbox_pkg::slave_burst_t exp,
        input string what
    );
        if (got !== exp)
        begin
            fail_run($sformatf(
                "FAILED at %0t: %s got addr %h count %0d last %b, expected %h %0d %b",
                $time, what, got.addr, got.count, got.last, exp.addr, exp.count, exp.last));
        end
    endtask

    task automatic check_idle
    (
        input logic got_ready,
        input logic got_valid,
        input logic exp_ready,
        input logic exp_valid,
        input string what
    );
        if (got_ready !== exp_ready || got_valid !== exp_valid)
        begin
            fail_run($sformatf("FAILED at %0t: %s cmd_ready %b burst_valid %b, expected %b %b",
                $time, what, got_ready, got_valid, exp_ready, exp_valid));
        end
    endtask

    task automatic check_number(input int got, input int exp, input string what);
        if (got != exp)
        begin
            fail_run($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // Sends one command on a falling edge and follows its bursts
    task automatic run_command(input stim_t entry);
        int idx;
        int cycles;
        logic accepted;
        logic done;

        build_expected(entry.addr, entry.count, exp_q);
        check_number(exp_q.size(), entry.bursts, "bursts in model");
        check_idle(cmd_ready, burst_valid, 1'b1, 1'b0, "before command");
        cmd       = {entry.addr, entry.count};
        cmd_valid = 1'b1;
        @(posedge clk);
        idx      = 0;
        cycles   = 0;
        accepted = 1'b0;
        done     = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            cmd_valid = 1'b0;
            // A burst accepted on the last rising edge has moved on
            if (accepted)
            begin
                idx++;
            end
            accepted = 1'b0;
            if (burst_valid)
            begin
                if (idx >= exp_q.size())
                begin
                    fail_run("The DUT offered a burst after the last expected one");
                end
                else
                begin
                    check_burst(burst, exp_q[idx], "burst");
                    check_idle(cmd_ready, burst_valid, 1'b0, 1'b1, "while busy");
                    accepted     = entry.backpressure ? ($urandom % 2 == 1) : 1'b1;
                    burst_accept = accepted;
                end
            end
            else
            begin
                burst_accept = 1'b0;
                done         = cmd_ready;
            end
        end
        check_number(idx, exp_q.size(), "bursts transferred");
        if (!entry.backpressure)
        begin
            check_number(cycles, exp_q.size() + 1, "cycles from command to ready");
        end
    endtask

    // Ends the run when the DUT stops making progress
    always @(posedge clk)
    begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit)
        begin
            fail_run("Timeout: the DUT did not finish the commands in time");
        end
    end

    initial
    begin
        seed_dummy   = $urandom(32'hedd9_e2f8);
        reset_n      = 1'b0;
        cmd          = '0;
        cmd_valid    = 1'b0;
        burst_accept = 1'b0;
        cycle_count  = 0;

        // Address, beats, back-pressure, expected number of bursts
        stim_table[0] = {16'h0114, 8'd5,   1'b0, 8'd1};
        stim_table[1] = {16'h0040, 8'd8,   1'b0, 8'd1};
        stim_table[2] = {16'h0010, 8'd40,  1'b0, 8'd5};
        stim_table[3] = {16'h003C, 8'd20,  1'b0, 8'd3};
        stim_table[4] = {16'h003D, 8'd128, 1'b1, 8'd17};
        stim_table[5] = {16'h003F, 8'd1,   1'b0, 8'd1};
        stim_table[6] = {16'h00FB, 8'd13,  1'b0, 8'd2};
        stim_table[7] = {16'h0238, 8'd33,  1'b1, 8'd5};
        stim_table[8] = {16'hFFFC, 8'd6,   1'b0, 8'd2};

        bursts_expected = 0;
        for (int i = 0; i < NUM_CMDS; i++)
        begin
            build_expected(stim_table[i].addr, stim_table[i].count, exp_q);
            bursts_expected += exp_q.size();
        end
        timeout_limit = 4 * (bursts_expected + 2 * NUM_CMDS) + 100;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_idle(cmd_ready, burst_valid, 1'b1, 1'b0, "after reset");

        // Each command starts on the falling edge where the previous one ended
        for (int i = 0; i < NUM_CMDS; i++)
        begin
            run_command(stim_table[i]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
+incdir+verification
hw/burst_gearbox_pkg.sv
hw/burst_split_ctrl.sv
hw/burst_addr_stepper.sv
hw/burst_remain_counter.sv
hw/burst_gearbox_top.sv
verification/burst_gearbox_tb.sv
